/* hdl/axi4Lite_params.svh */
`ifndef AXI4LITE_PARAMS_SVH
`define AXI4LITE_PARAMS_SVH

// Bus widths.
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32

// Host command buffering.
`define CMD_FIFO_DEPTH 4

// Slave register bank.
`define REG_COUNT 16

// Low registers that only take privileged writes.
`define PROT_REG_COUNT 4

`endif

/* hdl/axi4LitePkg.sv */
`default_nettype none

`include "axi4Lite_params.svh"

package axi4LitePkg;

  // ############################################################
  // Host command
  // ############################################################

  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0]   addr;
    logic [2:0]                    prot;
    logic [`AXIL_DATA_WIDTH-1:0]   data;
    logic [`AXIL_DATA_WIDTH/8-1:0] strb;
  } writeCmd_t;

  // ############################################################
  // AXI4-Lite write channels
  // ############################################################

  typedef struct packed {
    logic [`AXIL_ADDR_WIDTH-1:0] awaddr;
    logic [2:0]                  awprot;
  } awChan_t;

  typedef struct packed {
    logic [`AXIL_DATA_WIDTH-1:0]   wdata;
    logic [`AXIL_DATA_WIDTH/8-1:0] wstrb;
  } wChan_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } bresp_e;

  // Write master FSM.
  typedef enum logic [1:0] {
    DRV_IDLE,
    DRV_ADDR,
    DRV_RESP
  } drvState_e;

endpackage : axi4LitePkg

`default_nettype wire

/* hdl/cmdFifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axi4Lite_params.svh"

module cmdFifo (
  input  wire logic                  aclk,
  input  wire logic                  reset,
  input  wire logic                  push,
  input  wire axi4LitePkg::writeCmd_t pushData,
  input  wire logic                  pop,
  output axi4LitePkg::writeCmd_t     headData,
  output logic                       empty,
  output logic                       full
);

  localparam int DEPTH = `CMD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  axi4LitePkg::writeCmd_t mem [DEPTH];

  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             doPush;
  logic             doPop;

  assign doPush   = push && !full;
  assign doPop    = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  assign headData = mem[rdPtr];

  // Storage.
  always_ff @(posedge aclk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  // Pointers and occupancy.
  always_ff @(posedge aclk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule : cmdFifo

`default_nettype wire

/* hdl/axi4LiteMasterWriteDriver.sv */
`timescale 1ns/10ps
`default_nettype none

module axi4LiteMasterWriteDriver (
  input  wire logic                   aclk,
  input  wire logic                   reset,
  // Command FIFO side.
  input  wire axi4LitePkg::writeCmd_t fifoHead,
  input  wire logic                   fifoEmpty,
  output logic                        fifoPop,
  // Write address channel.
  output axi4LitePkg::awChan_t        awChan,
  output logic                        awvalid,
  input  wire logic                   awready,
  // Write data channel.
  output axi4LitePkg::wChan_t         wChan,
  output logic                        wvalid,
  input  wire logic                   wready,
  // Write response channel.
  input  wire axi4LitePkg::bresp_e    bresp,
  input  wire logic                   bvalid,
  output logic                        bready
);

  axi4LitePkg::drvState_e state;

  logic awDone;
  logic wDone;

  assign fifoPop = (state == axi4LitePkg::DRV_IDLE) && !fifoEmpty;
  assign bready  = (state == axi4LitePkg::DRV_RESP);

  // A channel is done once its valid has been taken.
  assign awDone = !awvalid || awready;
  assign wDone  = !wvalid || wready;

  // ############################################################
  // Control FSM
  // ############################################################

  always_ff @(posedge aclk) begin
    if (reset) begin
      state   <= axi4LitePkg::DRV_IDLE;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      case (state)
        axi4LitePkg::DRV_IDLE: begin
          if (fifoPop) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= axi4LitePkg::DRV_ADDR;
          end
        end
        axi4LitePkg::DRV_ADDR: begin
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (awDone && wDone) begin
            state <= axi4LitePkg::DRV_RESP;
          end
        end
        axi4LitePkg::DRV_RESP: begin
          if (bvalid) begin
            state <= axi4LitePkg::DRV_IDLE;
          end
        end
        default: state <= axi4LitePkg::DRV_IDLE;
      endcase
    end
  end

  // Payload held steady until the next pop.
  always_ff @(posedge aclk) begin
    if (fifoPop) begin
      awChan <= '{awaddr: fifoHead.addr, awprot: fifoHead.prot};
      wChan  <= '{wdata: fifoHead.data, wstrb: fifoHead.strb};
    end
  end

endmodule : axi4LiteMasterWriteDriver

`default_nettype wire

/* hdl/axi4LiteWriteSlaveRegs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axi4Lite_params.svh"

module axi4LiteWriteSlaveRegs (
  input  wire logic                          aclk,
  input  wire logic                          reset,
  input  wire logic                          stall,
  input  wire axi4LitePkg::awChan_t          awChan,
  input  wire logic                          awvalid,
  output logic                               awready,
  input  wire axi4LitePkg::wChan_t           wChan,
  input  wire logic                          wvalid,
  output logic                               wready,
  output axi4LitePkg::bresp_e                bresp,
  output logic                               bvalid,
  input  wire logic                          bready,
  input  wire logic [$clog2(`REG_COUNT)-1:0] readIndex,
  output logic [`AXIL_DATA_WIDTH-1:0]        readData
);

  localparam int ADDR_W = `AXIL_ADDR_WIDTH;
  localparam int DATA_W = `AXIL_DATA_WIDTH;
  localparam int STRB_W = DATA_W / 8;
  localparam int IDX_W  = $clog2(`REG_COUNT);

  logic [DATA_W-1:0] regs [`REG_COUNT];

  logic             accept;
  logic [IDX_W-1:0] wordIdx;
  logic             outOfRange;
  logic             protViolation;
  logic             writeErr;

  // Both channels taken together, never while a response is pending.
  assign accept  = awvalid && wvalid && !stall && !bvalid;
  assign awready = accept;
  assign wready  = accept;

  // ############################################################
  // Address decode and checks
  // ############################################################

  assign wordIdx       = awChan.awaddr[IDX_W+1:2];
  assign outOfRange    = |awChan.awaddr[ADDR_W-1:IDX_W+2];
  assign protViolation = (wordIdx < IDX_W'(`PROT_REG_COUNT)) && !awChan.awprot[0];
  assign writeErr      = outOfRange || protViolation;

  assign readData = regs[readIndex];

  // Response channel.
  always_ff @(posedge aclk) begin
    if (reset) begin
      bvalid <= 1'b0;
      bresp  <= axi4LitePkg::RESP_OKAY;
    end else if (accept) begin
      bvalid <= 1'b1;
      bresp  <= writeErr ? axi4LitePkg::RESP_SLVERR : axi4LitePkg::RESP_OKAY;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // Register bank with byte strobes.
  always_ff @(posedge aclk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (accept && !writeErr) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wChan.wstrb[b]) begin
          regs[wordIdx][8*b +: 8] <= wChan.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule : axi4LiteWriteSlaveRegs

`default_nettype wire

/* hdl/axi4LiteMasterWriteMonitor.sv */
`timescale 1ns/10ps
`default_nettype none

module axi4LiteMasterWriteMonitor (
  input  wire logic                aclk,
  input  wire logic                reset,
  input  wire logic                bvalid,
  input  wire logic                bready,
  input  wire axi4LitePkg::bresp_e bresp,
  output logic [7:0]               writeCount,
  output logic [7:0]               errorCount,
  output axi4LitePkg::bresp_e      lastResp
);

  logic respTaken;
  logic isError;

  // A write ends on the B handshake.
  assign respTaken = bvalid && bready;
  assign isError   = (bresp == axi4LitePkg::RESP_SLVERR);

  // ############################################################
  // Counters
  // ############################################################

  always_ff @(posedge aclk) begin
    if (reset) begin
      writeCount <= '0;
      errorCount <= '0;
      lastResp   <= axi4LitePkg::RESP_OKAY;
    end else if (respTaken) begin
      // Both counts wrap.
      writeCount <= writeCount + 8'd1;
      if (isError) begin
        errorCount <= errorCount + 8'd1;
      end
      lastResp <= bresp;
    end
  end

endmodule : axi4LiteMasterWriteMonitor

`default_nettype wire

/* hdl/axi4LiteWriteSubsystem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axi4Lite_params.svh"

module axi4LiteWriteSubsystem (
  input  wire logic                          aclk,
  input  wire logic                          reset,
  // Host commands.
  input  wire logic                          cmdValid,
  input  wire axi4LitePkg::writeCmd_t        cmd,
  output logic                               cmdFull,
  // Bus back-pressure.
  input  wire logic                          stall,
  // Observation.
  input  wire logic [$clog2(`REG_COUNT)-1:0] readIndex,
  output logic [`AXIL_DATA_WIDTH-1:0]        readData,
  output logic [7:0]                         writeCount,
  output logic [7:0]                         errorCount,
  output axi4LitePkg::bresp_e                lastResp
);

  axi4LitePkg::writeCmd_t fifoHead;
  logic                   fifoEmpty;
  logic                   fifoPop;

  // ############################################################
  // Internal write bus
  // ############################################################

  axi4LitePkg::awChan_t awChan;
  logic                 awvalid;
  logic                 awready;
  axi4LitePkg::wChan_t  wChan;
  logic                 wvalid;
  logic                 wready;
  axi4LitePkg::bresp_e  bresp;
  logic                 bvalid;
  logic                 bready;

  cmdFifo u_cmdFifo (
    .aclk     (aclk),
    .reset    (reset),
    .push     (cmdValid),
    .pushData (cmd),
    .pop      (fifoPop),
    .headData (fifoHead),
    .empty    (fifoEmpty),
    .full     (cmdFull)
  );

  axi4LiteMasterWriteDriver u_driver (
    .aclk      (aclk),
    .reset     (reset),
    .fifoHead  (fifoHead),
    .fifoEmpty (fifoEmpty),
    .fifoPop   (fifoPop),
    .awChan    (awChan),
    .awvalid   (awvalid),
    .awready   (awready),
    .wChan     (wChan),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready)
  );

  axi4LiteWriteSlaveRegs u_slave (
    .aclk      (aclk),
    .reset     (reset),
    .stall     (stall),
    .awChan    (awChan),
    .awvalid   (awvalid),
    .awready   (awready),
    .wChan     (wChan),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .readIndex (readIndex),
    .readData  (readData)
  );

  // Passive tap on the response channel.
  axi4LiteMasterWriteMonitor u_monitor (
    .aclk       (aclk),
    .reset      (reset),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .writeCount (writeCount),
    .errorCount (errorCount),
    .lastResp   (lastResp)
  );

endmodule : axi4LiteWriteSubsystem

`default_nettype wire

/* testbench/tbAxi4LiteWrite.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axi4Lite_params.svh"

module tbAxi4LiteWrite;

  // Well above the few hundred cycles the tests need.
  localparam int          TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] RNG_SEED       = 32'd85;

  logic                   aclk;
  logic                   reset;
  logic                   cmdValid;
  axi4LitePkg::writeCmd_t cmd;
  logic                   cmdFull;
  logic                   stall;
  logic [3:0]             readIndex;
  logic [31:0]            readData;
  logic [7:0]             writeCount;
  logic [7:0]             errorCount;
  axi4LitePkg::bresp_e    lastResp;

  // Reference model state.
  logic [31:0]         model [`REG_COUNT];
  logic [7:0]          expWrites;
  logic [7:0]          expErrors;
  axi4LitePkg::bresp_e expLast;
  logic [31:0]         rngState;

  int failCount;
  int failsAtStart;
  int testsRun;
  int testsFailed;

  axi4LiteWriteSubsystem u_dut (
    .aclk       (aclk),
    .reset      (reset),
    .cmdValid   (cmdValid),
    .cmd        (cmd),
    .cmdFull    (cmdFull),
    .stall      (stall),
    .readIndex  (readIndex),
    .readData   (readData),
    .writeCount (writeCount),
    .errorCount (errorCount),
    .lastResp   (lastResp)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  initial begin : watchdog
    int cycleCount;
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge aclk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("sim failed");
    $finish;
  end

  // ##########################################################
  // Helpers
  // ##########################################################

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] regAddr(input logic [3:0] idx);
    return {26'd0, idx, 2'b00};
  endfunction

  function automatic axi4LitePkg::writeCmd_t makeCmd(input logic [31:0] addr,
      input logic [2:0] prot, input logic [31:0] data, input logic [3:0] strb);
    axi4LitePkg::writeCmd_t c;
    c.addr = addr;
    c.prot = prot;
    c.data = data;
    c.strb = strb;
    return c;
  endfunction

  task automatic randomWord(output logic [31:0] r);
    rngState = xorshift32(rngState);
    r = rngState;
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s got 0x%08h, expected 0x%08h", name, got, exp);
      failCount++;
    end
  endtask

  // Slave rules: range check, protection, then byte merge.
  task automatic applyModel(input axi4LitePkg::writeCmd_t c);
    logic [3:0] idx;
    logic       err;
    idx = c.addr[5:2];
    err = (|c.addr[`AXIL_ADDR_WIDTH-1:6]) ||
          ((idx < 4'(`PROT_REG_COUNT)) && !c.prot[0]);
    expWrites = expWrites + 8'd1;
    if (err) begin
      expErrors = expErrors + 8'd1;
      expLast   = axi4LitePkg::RESP_SLVERR;
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (c.strb[b]) begin
          model[idx][8*b +: 8] = c.data[8*b +: 8];
        end
      end
      expLast = axi4LitePkg::RESP_OKAY;
    end
  endtask

  // One-cycle strobe; a strobe seen while full is dropped.
  task automatic strobeCmd(input axi4LitePkg::writeCmd_t c);
    cmd      = c;
    cmdValid = 1'b1;
    if (!cmdFull) begin
      applyModel(c);
    end
    @(negedge aclk);
    cmdValid = 1'b0;
  endtask

  task automatic pushCmd(input axi4LitePkg::writeCmd_t c);
    while (cmdFull) begin
      @(negedge aclk);
    end
    strobeCmd(c);
  endtask

  task automatic waitWrites();
    while (writeCount !== expWrites) begin
      @(negedge aclk);
    end
  endtask

  task automatic checkState();
    checkValue("writeCount", 32'(writeCount), 32'(expWrites));
    checkValue("errorCount", 32'(errorCount), 32'(expErrors));
    checkValue("lastResp", 32'(lastResp), 32'(expLast));
    for (int i = 0; i < `REG_COUNT; i++) begin
      readIndex = 4'(i);
      @(negedge aclk);
      checkValue($sformatf("readData[%0d]", i), readData, model[4'(i)]);
    end
  endtask

  task automatic reportTest(input string name);
    testsRun++;
    if (failCount == failsAtStart) begin
      $display("Test %0d %s: ok", testsRun, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: FAILED with %0d errors", testsRun, name,
               failCount - failsAtStart);
    end
    failsAtStart = failCount;
  endtask

  // ##########################################################
  // Test sequence
  // ##########################################################

  initial begin : mainFlow
    logic [31:0] d;
    logic [31:0] s;
    reset     = 1'b1;
    cmdValid  = 1'b0;
    cmd       = '0;
    stall     = 1'b0;
    readIndex = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model[4'(i)] = '0;
    end
    expWrites    = '0;
    expErrors    = '0;
    expLast      = axi4LitePkg::RESP_OKAY;
    rngState     = RNG_SEED;
    failCount    = 0;
    failsAtStart = 0;
    testsRun     = 0;
    testsFailed  = 0;

    repeat (16) @(negedge aclk);
    reset = 1'b0;
    @(negedge aclk);

    checkValue("cmdFull", 32'(cmdFull), 32'd0);
    checkState();
    reportTest("reset state");

    for (int i = 0; i < `REG_COUNT; i++) begin
      randomWord(d);
      randomWord(s);
      pushCmd(makeCmd(regAddr(4'(i)), 3'b001, d, s[3:0]));
    end
    waitWrites();
    checkState();
    reportTest("privileged writes");

    // Open registers first so the run ends on a rejected write.
    for (int i = `PROT_REG_COUNT; i < `REG_COUNT; i++) begin
      randomWord(d);
      pushCmd(makeCmd(regAddr(4'(i)), 3'b000, d, 4'hF));
    end
    for (int i = 0; i < `PROT_REG_COUNT; i++) begin
      randomWord(d);
      pushCmd(makeCmd(regAddr(4'(i)), 3'b000, d, 4'hF));
    end
    waitWrites();
    checkState();
    reportTest("protection");

    randomWord(d);
    pushCmd(makeCmd(32'h0000_0044, 3'b001, d, 4'hF));
    randomWord(d);
    pushCmd(makeCmd(32'h8000_0008, 3'b111, d, 4'hF));
    waitWrites();
    checkState();
    reportTest("out-of-range address");

    stall = 1'b1;
    for (int k = 0; k < 5; k++) begin
      randomWord(d);
      randomWord(s);
      pushCmd(makeCmd(regAddr(4'(8 + k % 3)), 3'b001, d, s[3:0]));
    end
    checkValue("cmdFull", 32'(cmdFull), 32'd1);
    // Sent while full, so it must never land.
    strobeCmd(makeCmd(regAddr(4'd11), 3'b001, 32'hDEAD_BEEF, 4'hF));
    stall = 1'b0;
    waitWrites();
    checkState();
    checkValue("cmdFull", 32'(cmdFull), 32'd0);
    reportTest("back-pressure");

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             testsRun, testsFailed, failCount);
    if (failCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : tbAxi4LiteWrite

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/axi4LitePkg.sv
hdl/cmdFifo.sv
hdl/axi4LiteMasterWriteDriver.sv
hdl/axi4LiteWriteSlaveRegs.sv
hdl/axi4LiteMasterWriteMonitor.sv
hdl/axi4LiteWriteSubsystem.sv
testbench/tbAxi4LiteWrite.sv

/* Makefile */
# Verilator flow for the AXI4-Lite write subsystem.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tbAxi4LiteWrite
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation finished, see $(LOG)"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
